/* design/lsuPkg.sv */
package lsuPkg;

    // data path and address widths
    localparam int dataWidth = 64;
    localparam int addrWidth = 64;

    // one strobe bit per data byte
    localparam int maskWidth = dataWidth / 8;

    // load type field from the instruction
    localparam int func3Width = 3;

    // register file index
    localparam int regAddrWidth = 5;

    // func3 codes for the load instructions
    localparam logic [func3Width-1:0] loadByte = 3'd0;
    localparam logic [func3Width-1:0] loadHalf = 3'd1;
    localparam logic [func3Width-1:0] loadWord = 3'd2;
    localparam logic [func3Width-1:0] loadDouble = 3'd3;
    localparam logic [func3Width-1:0] loadByteUnsigned = 3'd4;
    localparam logic [func3Width-1:0] loadHalfUnsigned = 3'd5;
    localparam logic [func3Width-1:0] loadWordUnsigned = 3'd6;

    // address nibble that selects main memory
    localparam int memoryTagLow = 28;
    localparam int memoryTagHigh = 31;
    localparam int memoryTagWidth = memoryTagHigh - memoryTagLow + 1;

    // 0x8xxx_xxxx goes to the data cache, the rest to devices
    localparam logic [memoryTagWidth-1:0] memoryRegionTag = 4'h8;

endpackage

/* design/accessRouter.sv */
`timescale 1ns/1ps

module accessRouter (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         exValid,
    input  logic                         exReadFlag,
    input  logic                         exWriteFlag,
    input  logic [lsuPkg::addrWidth-1:0] exAddress,
    input  logic                         wbReady,
    input  logic                         cacheDataOk,
    input  logic                         deviceReadBusy,
    input  logic                         deviceWriteBusy,
    output logic                         cacheValid,
    output logic                         cacheWrite,
    output logic                         deviceReadRequest,
    output logic                         deviceWriteRequest,
    output logic                         skipRef,
    output logic                         exReady,
    output logic                         wbValid
);

    typedef enum logic {
        idle,
        waiting
    } cacheState_t;

    cacheState_t cacheState;
    cacheState_t cacheNextState;

    logic isMemory;
    logic accessRequested;
    logic cacheBusy;
    logic busy;

    // region decode on the top address nibble only
    assign isMemory = exAddress[lsuPkg::memoryTagHigh:lsuPkg::memoryTagLow]
                      == lsuPkg::memoryRegionTag;

    // any load or store from a valid instruction
    assign accessRequested = exValid && (exReadFlag || exWriteFlag);

    // request drops in the dataok cycle
    // otherwise the cache would start a second lookup right away
    assign cacheValid = accessRequested && isMemory && !cacheDataOk;

    // a load takes priority over the store flag
    assign cacheWrite = exWriteFlag && !exReadFlag;

    // device side, one channel per direction
    assign deviceReadRequest = exValid && exReadFlag && !isMemory;
    assign deviceWriteRequest = exValid && exWriteFlag && !isMemory;

    // device accesses are not checked against the reference model
    assign skipRef = accessRequested && !isMemory;

    always_ff @(posedge clock) begin
        if (reset) begin
            cacheState <= idle;
        end else begin
            cacheState <= cacheNextState;
        end
    end

    always_comb begin
        cacheNextState = cacheState;
        case (cacheState)
            idle: begin
                if (cacheValid) begin
                    cacheNextState = waiting;
                end
            end
            waiting: begin
                // back to idle on the edge after dataok
                if (cacheDataOk) begin
                    cacheNextState = idle;
                end
            end
            default: begin
                cacheNextState = idle;
            end
        endcase
    end

    // busy from the request until the dataok cycle
    assign cacheBusy = (cacheState == idle && cacheValid)
                       || (cacheState == waiting && !cacheDataOk);

    assign busy = cacheBusy || deviceReadBusy || deviceWriteBusy;

    // stall execute, hold back writeback
    assign exReady = wbReady && !busy;
    assign wbValid = exValid && !busy;

endmodule

/* design/deviceReadFsm.sv */
`timescale 1ns/1ps

module deviceReadFsm (
    input  logic clock,
    input  logic reset,
    input  logic deviceReadRequest,
    input  logic arReady,
    input  logic rValid,
    output logic arValid,
    output logic rReady,
    output logic readDataTaken,
    output logic deviceReadBusy
);

    typedef enum logic [1:0] {
        idle,
        waitAddressReady,
        readData
    } readState_t;

    readState_t state;
    readState_t nextState;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (arValid && arReady) begin
                    nextState = readData;
                end else if (arValid) begin
                    nextState = waitAddressReady;
                end
            end
            waitAddressReady: begin
                // address held until the device takes it
                if (arReady) begin
                    nextState = readData;
                end
            end
            readData: begin
                // single beat, done after one data transfer
                if (rValid) begin
                    nextState = idle;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // address valid straight from the request while idle
    assign arValid = (state == idle && deviceReadRequest) || state == waitAddressReady;
    assign rReady = state == readData;
    assign readDataTaken = rReady && rValid;

    // low again in the data handshake cycle
    assign deviceReadBusy = (state == idle && deviceReadRequest)
                            || state == waitAddressReady
                            || (state == readData && !rValid);

endmodule

/* design/deviceWriteFsm.sv */
`timescale 1ns/1ps

module deviceWriteFsm (
    input  logic clock,
    input  logic reset,
    input  logic deviceWriteRequest,
    input  logic awReady,
    input  logic wReady,
    output logic awValid,
    output logic wValid,
    output logic deviceWriteBusy
);

    typedef enum logic [1:0] {
        idle,
        waitAddressReady,
        writeData
    } writeState_t;

    writeState_t state;
    writeState_t nextState;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (awValid && awReady) begin
                    nextState = writeData;
                end else if (awValid) begin
                    nextState = waitAddressReady;
                end
            end
            waitAddressReady: begin
                if (awReady) begin
                    nextState = writeData;
                end
            end
            writeData: begin
                // no response channel, finished once the beat is taken
                if (wReady) begin
                    nextState = idle;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // address first, data beat only after the address is accepted
    assign awValid = (state == idle && deviceWriteRequest) || state == waitAddressReady;
    assign wValid = state == writeData;

    // store retires in the cycle the beat goes out
    assign deviceWriteBusy = (state == idle && deviceWriteRequest)
                             || state == waitAddressReady
                             || (state == writeData && !wReady);

endmodule

/* design/loadResultFormatter.sv */
`timescale 1ns/1ps

module loadResultFormatter (
    input  logic                          readFlag,
    input  logic [lsuPkg::func3Width-1:0] func3,
    input  logic [lsuPkg::dataWidth-1:0]  cacheData,
    input  logic                          cacheDataOk,
    input  logic [lsuPkg::dataWidth-1:0]  rData,
    input  logic                          readDataTaken,
    output logic [lsuPkg::dataWidth-1:0]  loadResult
);

    logic [lsuPkg::dataWidth-1:0] rawData;

    // cache wins, device data only in its handshake cycle
    always_comb begin
        if (cacheDataOk) begin
            rawData = cacheData;
        end else if (readDataTaken) begin
            rawData = rData;
        end else begin
            rawData = '0;
        end
    end

    // extend the low byte, half or word by load type
    always_comb begin
        if (!readFlag) begin
            loadResult = '0;
        end else begin
            case (func3)
                lsuPkg::loadByte:
                    loadResult = {{56{rawData[7]}}, rawData[7:0]};
                lsuPkg::loadHalf:
                    loadResult = {{48{rawData[15]}}, rawData[15:0]};
                lsuPkg::loadWord:
                    loadResult = {{32{rawData[31]}}, rawData[31:0]};
                lsuPkg::loadDouble:
                    loadResult = rawData;
                lsuPkg::loadByteUnsigned:
                    loadResult = {56'd0, rawData[7:0]};
                lsuPkg::loadHalfUnsigned:
                    loadResult = {48'd0, rawData[15:0]};
                lsuPkg::loadWordUnsigned:
                    loadResult = {32'd0, rawData[31:0]};
                // unknown code, data as returned
                default:
                    loadResult = rawData;
            endcase
        end
    end

endmodule

/* design/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic                            clock,
    input  logic                            reset,
    // from execute
    input  logic                            exValid,
    input  logic                            exReadFlag,
    input  logic                            exWriteFlag,
    input  logic [lsuPkg::addrWidth-1:0]    exAddress,
    input  logic [lsuPkg::dataWidth-1:0]    exWriteData,
    input  logic [lsuPkg::maskWidth-1:0]    exWriteMask,
    input  logic [lsuPkg::func3Width-1:0]   exFunc3,
    input  logic [lsuPkg::addrWidth-1:0]    exPc,
    input  logic [lsuPkg::regAddrWidth-1:0] exWaddr,
    input  logic                            exWen,
    output logic                            exReady,
    // to writeback
    input  logic                            wbReady,
    output logic                            wbValid,
    output logic [lsuPkg::addrWidth-1:0]    wbPc,
    output logic [lsuPkg::regAddrWidth-1:0] wbWaddr,
    output logic                            wbWen,
    output logic                            wbReadFlag,
    output logic [lsuPkg::dataWidth-1:0]    wbAluResult,
    output logic [lsuPkg::dataWidth-1:0]    wbLoadResult,
    output logic                            wbSkipRef,
    // data cache
    output logic                            cacheValid,
    output logic                            cacheWrite,
    output logic [lsuPkg::addrWidth-1:0]    cacheAddress,
    output logic [lsuPkg::dataWidth-1:0]    cacheWriteData,
    output logic [lsuPkg::maskWidth-1:0]    cacheWriteMask,
    input  logic [lsuPkg::dataWidth-1:0]    cacheData,
    input  logic                            cacheDataOk,
    // device read channels
    output logic                            arValid,
    input  logic                            arReady,
    output logic [lsuPkg::addrWidth-1:0]    arAddress,
    input  logic                            rValid,
    output logic                            rReady,
    input  logic [lsuPkg::dataWidth-1:0]    rData,
    // device write channels
    output logic                            awValid,
    input  logic                            awReady,
    output logic [lsuPkg::addrWidth-1:0]    awAddress,
    output logic                            wValid,
    input  logic                            wReady,
    output logic [lsuPkg::dataWidth-1:0]    wData,
    output logic [lsuPkg::maskWidth-1:0]    wStrobe
);

    logic deviceReadRequest;
    logic deviceWriteRequest;
    logic deviceReadBusy;
    logic deviceWriteBusy;
    logic readDataTaken;

    // address, data and mask fan out to both targets
    assign cacheAddress = exAddress;
    assign arAddress = exAddress;
    assign awAddress = exAddress;
    assign cacheWriteData = exWriteData;
    assign wData = exWriteData;
    assign cacheWriteMask = exWriteMask;
    assign wStrobe = exWriteMask;

    // sideband for writeback, address doubles as the alu result
    assign wbPc = exPc;
    assign wbWaddr = exWaddr;
    assign wbWen = exWen;
    assign wbReadFlag = exReadFlag;
    assign wbAluResult = exAddress;

    accessRouter accessRouter_i (
        .clock              (clock),
        .reset              (reset),
        .exValid            (exValid),
        .exReadFlag         (exReadFlag),
        .exWriteFlag        (exWriteFlag),
        .exAddress          (exAddress),
        .wbReady            (wbReady),
        .cacheDataOk        (cacheDataOk),
        .deviceReadBusy     (deviceReadBusy),
        .deviceWriteBusy    (deviceWriteBusy),
        .cacheValid         (cacheValid),
        .cacheWrite         (cacheWrite),
        .deviceReadRequest  (deviceReadRequest),
        .deviceWriteRequest (deviceWriteRequest),
        .skipRef            (wbSkipRef),
        .exReady            (exReady),
        .wbValid            (wbValid)
    );

    deviceReadFsm deviceReadFsm_i (
        .clock             (clock),
        .reset             (reset),
        .deviceReadRequest (deviceReadRequest),
        .arReady           (arReady),
        .rValid            (rValid),
        .arValid           (arValid),
        .rReady            (rReady),
        .readDataTaken     (readDataTaken),
        .deviceReadBusy    (deviceReadBusy)
    );

    deviceWriteFsm deviceWriteFsm_i (
        .clock              (clock),
        .reset              (reset),
        .deviceWriteRequest (deviceWriteRequest),
        .awReady            (awReady),
        .wReady             (wReady),
        .awValid            (awValid),
        .wValid             (wValid),
        .deviceWriteBusy    (deviceWriteBusy)
    );

    loadResultFormatter loadResultFormatter_i (
        .readFlag      (exReadFlag),
        .func3         (exFunc3),
        .cacheData     (cacheData),
        .cacheDataOk   (cacheDataOk),
        .rData         (rData),
        .readDataTaken (readDataTaken),
        .loadResult    (wbLoadResult)
    );

endmodule

/* testbench/loadStoreUnitTb.sv */
`timescale 1ns/1ps

// device side ready or valid raised some extra cycles after the request
module delayedResponder (
    input  logic       clock,
    input  logic       reset,
    input  logic       request,
    input  logic [1:0] delay,
    output logic       response,
    output int         handshakes
);
    int waitCount;

    initial response = 1'b0;

    always @(posedge clock) begin
        if (reset) begin
            response <= 1'b0;
            waitCount <= 0;
            handshakes <= 0;
        end else if (request && response) begin
            // quiet after a transfer until the next request
            response <= 1'b0;
            waitCount <= 0;
            handshakes <= handshakes + 1;
        end else if (request) begin
            if (waitCount >= delay) begin
                response <= 1'b1;
            end else begin
                waitCount <= waitCount + 1;
            end
        end
    end
endmodule

module loadStoreUnitTb;

    localparam int numTests = 12;
    localparam int readyLimit = 40;

    logic clock;
    logic reset;
    logic exValid, exReadFlag, exWriteFlag, exWen, exReady;
    logic [lsuPkg::addrWidth-1:0] exAddress, exPc;
    logic [lsuPkg::dataWidth-1:0] exWriteData;
    logic [lsuPkg::maskWidth-1:0] exWriteMask;
    logic [lsuPkg::func3Width-1:0] exFunc3;
    logic [lsuPkg::regAddrWidth-1:0] exWaddr, wbWaddr;
    logic wbReady, wbValid, wbWen, wbReadFlag, wbSkipRef;
    logic [lsuPkg::addrWidth-1:0] wbPc;
    logic [lsuPkg::dataWidth-1:0] wbAluResult, wbLoadResult;
    logic cacheValid, cacheWrite, cacheDataOk;
    logic [lsuPkg::addrWidth-1:0] cacheAddress, arAddress, awAddress;
    logic [lsuPkg::dataWidth-1:0] cacheWriteData, cacheData, rData, wData;
    logic [lsuPkg::maskWidth-1:0] cacheWriteMask, wStrobe;
    logic arValid, arReady, rValid, rReady, awValid, awReady, wValid, wReady;

    // extra cycles of model latency
    logic [1:0] cacheDelay, arDelay, rDelay, awDelay, wDelay;
    int cacheCount;
    int readHandshakes, writeHandshakes;
    int errorCount = 0;
    int testCount = 0;
    logic cacheSeen;
    logic [31:0] lcgState = 32'ha4d8f727;
    // sideband sent with the current instruction
    logic [lsuPkg::addrWidth-1:0] pcValue;
    logic [lsuPkg::regAddrWidth-1:0] waddrValue;
    logic wenValue;

    loadStoreUnit loadStoreUnit_i (.*);

    delayedResponder arModel (
        .clock(clock), .reset(reset), .request(arValid), .delay(arDelay),
        .response(arReady), .handshakes()
    );
    // read data follows rReady with one beat per read
    delayedResponder rModel (
        .clock(clock), .reset(reset), .request(rReady), .delay(rDelay),
        .response(rValid), .handshakes(readHandshakes)
    );
    delayedResponder awModel (
        .clock(clock), .reset(reset), .request(awValid), .delay(awDelay),
        .response(awReady), .handshakes()
    );
    delayedResponder wModel (
        .clock(clock), .reset(reset), .request(wValid), .delay(wDelay),
        .response(wReady), .handshakes(writeHandshakes)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // cache answers 1 to 4 cycles after cacheValid with a one-cycle dataok pulse
    always @(posedge clock) begin
        if (reset) begin
            cacheDataOk <= 1'b0;
            cacheCount <= 0;
        end else if (cacheDataOk) begin
            cacheDataOk <= 1'b0;
            cacheCount <= 0;
        end else if (cacheValid) begin
            if (cacheCount >= cacheDelay) begin
                cacheDataOk <= 1'b1;
            end else begin
                cacheCount <= cacheCount + 1;
            end
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [1:0] randomDelay();
        logic [31:0] word;
        word = nextRandom();
        return word[1:0];
    endfunction

    // shift the field to the top and back down signed or unsigned
    function automatic logic [63:0] expectedLoad(input logic [2:0] f3, input logic [63:0] raw);
        logic [63:0] value;
        int shift;
        case (f3)
            lsuPkg::loadByte, lsuPkg::loadByteUnsigned: shift = 56;
            lsuPkg::loadHalf, lsuPkg::loadHalfUnsigned: shift = 48;
            lsuPkg::loadWord, lsuPkg::loadWordUnsigned: shift = 32;
            default: shift = 0;
        endcase
        value = raw << shift;
        if (f3 == lsuPkg::loadByte || f3 == lsuPkg::loadHalf || f3 == lsuPkg::loadWord) begin
            value = $signed(value) >>> shift;
        end else begin
            value = value >> shift;
        end
        return value;
    endfunction

    task automatic checkValue(input string testName, input string field,
                              input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %h actual %h", testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string testName, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("%s: pass", testName);
        end else begin
            $display("%s: fail, %0d mismatches", testName, errorCount - startErrors);
        end
    endtask

    // new instruction from execute with random sideband
    task automatic issueAccess(input logic readFlag, input logic writeFlag,
                               input logic [63:0] address, input logic [63:0] writeData,
                               input logic [7:0] mask, input logic [2:0] func3);
        logic [31:0] word;
        word = nextRandom();
        pcValue = {32'd0, word[31:2], 2'b00};
        waddrValue = word[6:2];
        wenValue = word[0];
        @(posedge clock);
        exValid <= 1'b1;
        exReadFlag <= readFlag;
        exWriteFlag <= writeFlag;
        exAddress <= address;
        exWriteData <= writeData;
        exWriteMask <= mask;
        exFunc3 <= func3;
        exPc <= pcValue;
        exWaddr <= waddrValue;
        exWen <= wenValue;
    endtask

    // instruction leaves on the edge after exReady was seen
    task automatic releaseAccess();
        @(posedge clock);
        exValid <= 1'b0;
        exReadFlag <= 1'b0;
        exWriteFlag <= 1'b0;
    endtask

    // called at a falling edge and returns at the falling edge where exReady is high
    task automatic waitForReady(input string testName);
        int cycles;
        cycles = 0;
        cacheSeen = 1'b0;
        while (!exReady && cycles < readyLimit) begin
            cacheSeen = cacheSeen | cacheValid;
            cycles++;
            @(negedge clock);
        end
        cacheSeen = cacheSeen | cacheValid;
        if (!exReady) begin
            $display("%s: exReady did not rise within %0d cycles", testName, readyLimit);
            errorCount++;
        end
    endtask

    task automatic cacheLoadTest(input logic [2:0] func3);
        string testName;
        int startErrors;
        logic [63:0] raw;
        testName = $sformatf("cache load func3 %0d", func3);
        startErrors = errorCount;
        // sign bits set so sign and zero extension differ
        raw = {nextRandom(), nextRandom()} | 64'h8000_8080;
        cacheDelay = randomDelay();
        issueAccess(1'b1, 1'b0, 64'h8000_0100 + func3 * 8, 64'd0, 8'd0, func3);
        cacheData <= raw;
        @(negedge clock);
        waitForReady(testName);
        checkValue(testName, "wbLoadResult", expectedLoad(func3, raw), wbLoadResult);
        checkValue(testName, "cacheWrite", 0, cacheWrite);
        checkValue(testName, "wbSkipRef", 0, wbSkipRef);
        checkValue(testName, "wbReadFlag", 1, wbReadFlag);
        releaseAccess();
        finishTest(testName, startErrors);
    endtask

    task automatic cacheStoreTest();
        int startErrors;
        logic [63:0] data;
        startErrors = errorCount;
        data = {nextRandom(), nextRandom()};
        cacheDelay = randomDelay();
        issueAccess(1'b0, 1'b1, 64'h8000_2008, data, 8'h3c, lsuPkg::loadDouble);
        @(negedge clock);
        checkValue("cache store", "cacheValid", 1, cacheValid);
        checkValue("cache store", "cacheWrite", 1, cacheWrite);
        checkValue("cache store", "cacheAddress", 64'h8000_2008, cacheAddress);
        checkValue("cache store", "cacheWriteData", data, cacheWriteData);
        checkValue("cache store", "cacheWriteMask", 8'h3c, cacheWriteMask);
        waitForReady("cache store");
        // ready may only come with dataok
        checkValue("cache store", "cacheDataOk", 1, cacheDataOk);
        releaseAccess();
        finishTest("cache store", startErrors);
    endtask

    task automatic deviceReadTest();
        int startErrors;
        int startReads;
        logic [63:0] raw;
        startErrors = errorCount;
        startReads = readHandshakes;
        raw = {nextRandom(), nextRandom()};
        arDelay = randomDelay();
        rDelay = randomDelay();
        issueAccess(1'b1, 1'b0, 64'h1000_0040, 64'd0, 8'd0, lsuPkg::loadWord);
        rData <= raw;
        @(negedge clock);
        checkValue("device read", "arValid", 1, arValid);
        checkValue("device read", "arAddress", 64'h1000_0040, arAddress);
        waitForReady("device read");
        checkValue("device read", "wbLoadResult", expectedLoad(lsuPkg::loadWord, raw),
                   wbLoadResult);
        checkValue("device read", "wbSkipRef", 1, wbSkipRef);
        releaseAccess();
        @(negedge clock);
        checkValue("device read", "read handshakes", 1, readHandshakes - startReads);
        finishTest("device read", startErrors);
    endtask

    task automatic deviceWriteTest();
        int startErrors;
        int startWrites;
        logic [63:0] data;
        startErrors = errorCount;
        startWrites = writeHandshakes;
        data = {nextRandom(), nextRandom()};
        awDelay = randomDelay();
        wDelay = randomDelay();
        issueAccess(1'b0, 1'b1, 64'h2000_0010, data, 8'hf0, lsuPkg::loadDouble);
        @(negedge clock);
        checkValue("device write", "awValid", 1, awValid);
        checkValue("device write", "awAddress", 64'h2000_0010, awAddress);
        checkValue("device write", "wData", data, wData);
        checkValue("device write", "wStrobe", 8'hf0, wStrobe);
        waitForReady("device write");
        checkValue("device write", "wbSkipRef", 1, wbSkipRef);
        checkValue("device write", "cacheValid seen", 0, cacheSeen);
        releaseAccess();
        @(negedge clock);
        checkValue("device write", "write handshakes", 1, writeHandshakes - startWrites);
        finishTest("device write", startErrors);
    endtask

    task automatic nonMemoryTest();
        int startErrors;
        startErrors = errorCount;
        issueAccess(1'b0, 1'b0, 64'h1234_5678_9abc_def0, 64'd0, 8'd0, 3'd0);
        @(negedge clock);
        checkValue("non memory", "exReady", wbReady, exReady);
        checkValue("non memory", "wbValid", exValid, wbValid);
        checkValue("non memory", "wbLoadResult", 0, wbLoadResult);
        checkValue("non memory", "wbPc", pcValue, wbPc);
        checkValue("non memory", "wbWaddr", waddrValue, wbWaddr);
        checkValue("non memory", "wbWen", wenValue, wbWen);
        checkValue("non memory", "wbReadFlag", 0, wbReadFlag);
        checkValue("non memory", "wbAluResult", 64'h1234_5678_9abc_def0, wbAluResult);
        // stalled writeback passes straight back to execute
        @(posedge clock);
        wbReady <= 1'b0;
        @(negedge clock);
        checkValue("non memory", "exReady", wbReady, exReady);
        checkValue("non memory", "wbValid", exValid, wbValid);
        releaseAccess();
        wbReady <= 1'b1;
        finishTest("non memory", startErrors);
    endtask

    task automatic backPressureTest();
        int startErrors;
        logic [63:0] raw;
        startErrors = errorCount;
        raw = {nextRandom(), nextRandom()} | 64'h8000_8080;
        cacheDelay = randomDelay();
        issueAccess(1'b1, 1'b0, 64'h8000_3000, 64'd0, 8'd0, lsuPkg::loadHalfUnsigned);
        wbReady <= 1'b0;
        cacheData <= raw;
        // cache may answer several times while writeback is stalled
        repeat (8) begin
            @(negedge clock);
            checkValue("back pressure", "exReady", 0, exReady);
        end
        @(posedge clock);
        wbReady <= 1'b1;
        @(negedge clock);
        waitForReady("back pressure");
        checkValue("back pressure", "wbLoadResult",
                   expectedLoad(lsuPkg::loadHalfUnsigned, raw), wbLoadResult);
        releaseAccess();
        finishTest("back pressure", startErrors);
    endtask

    // stop a stuck run
    initial begin
        repeat (numTests * 50) @(posedge clock);
        $display("timeout, tests still running after %0d cycles", numTests * 50);
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        wbReady = 1'b1;
        exValid = 1'b0;
        exReadFlag = 1'b0;
        exWriteFlag = 1'b0;
        exAddress = '0;
        exWriteData = '0;
        exWriteMask = '0;
        exFunc3 = '0;
        exPc = '0;
        exWaddr = '0;
        exWen = 1'b0;
        cacheData = '0;
        cacheDataOk = 1'b0;
        rData = '0;
        cacheDelay = 2'd0;
        arDelay = 2'd0;
        rDelay = 2'd0;
        awDelay = 2'd0;
        wDelay = 2'd0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int code = 0; code < 7; code++) begin
            cacheLoadTest(code[2:0]);
        end
        cacheStoreTest();
        deviceReadTest();
        deviceWriteTest();
        nonMemoryTest();
        backPressureTest();
        $display("%0d tests run, %0d mismatches", testCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* loadStoreUnit.f */
design/lsuPkg.sv
design/accessRouter.sv
design/deviceReadFsm.sv
design/deviceWriteFsm.sv
design/loadResultFormatter.sv
design/loadStoreUnit.sv
testbench/loadStoreUnitTb.sv
